// File: ooo_pkg.sv
package ooo_pkg;

    // reorder buffer size
    localparam int ROB_DEPTH = 16;

    // multiplier pipeline depth
    localparam int MUL_STAGES = 3;

    // data and register widths
    typedef logic [31:0] word_t;
    typedef logic [63:0] prod_t;
    typedef logic [4:0]  reg_addr_t;

    // rob slot index
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;
    // occupancy, one bit wider so a full buffer is representable
    typedef logic [$clog2(ROB_DEPTH):0]   rob_cnt_t;

    // target execution unit
    typedef enum logic {
        UNIT_ALU = 1'b0,
        UNIT_MUL = 1'b1
    } unit_t;

    // alu op codes
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_t;

    // multiplier reuses the op field
    localparam alu_op_t MUL_LO  = alu_op_t'(3'd0);
    localparam alu_op_t MUL_HIU = alu_op_t'(3'd1);

    // per slot state
    typedef enum logic [1:0] {
        ST_EMPTY = 2'd0,
        ST_WAIT  = 2'd1,
        ST_DONE  = 2'd2
    } entry_status_t;

    // front end to rob
    typedef struct packed {
        unit_t     unit;
        alu_op_t   op;
        reg_addr_t rd_addr;
        word_t     src_a;
        word_t     src_b;
    } dispatch_t;

    // rob to execution units
    typedef struct packed {
        rob_idx_t rob_idx;
        alu_op_t  op;
        word_t    src_a;
        word_t    src_b;
    } issue_t;

    // one result channel
    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        word_t    data;
    } cdb_t;

    // retirement record
    typedef struct packed {
        rob_idx_t  rob_idx;
        reg_addr_t rd_addr;
        word_t     rd_data;
    } commit_t;

endpackage

// File: alu_unit.sv
`timescale 1ns/1ns

module alu_unit (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            issue_valid_i,
    input  ooo_pkg::issue_t issue_i,
    output ooo_pkg::cdb_t   cdb_o
);

    import ooo_pkg::*;

    word_t    result;
    logic [4:0] shamt;

    // only low five bits of b shift
    assign shamt = issue_i.src_b[4:0];

    always_comb begin
        result = '0;
        case (issue_i.op)
            ALU_ADD: result = issue_i.src_a + issue_i.src_b;
            ALU_SUB: result = issue_i.src_a - issue_i.src_b;
            ALU_AND: result = issue_i.src_a & issue_i.src_b;
            ALU_OR:  result = issue_i.src_a | issue_i.src_b;
            ALU_XOR: result = issue_i.src_a ^ issue_i.src_b;
            ALU_SLL: result = issue_i.src_a << shamt;
            // logical, zero fill
            ALU_SRL: result = issue_i.src_a >> shamt;
            // signed compare gives 1 or 0
            ALU_SLT: result = ($signed(issue_i.src_a) < $signed(issue_i.src_b)) ? 32'd1 : 32'd0;
            default: result = '0;
        endcase
    end

    // valid on the bus the cycle after issue
    always_ff @(posedge clk) begin
        if (rst_i) begin
            cdb_o.valid <= 1'b0;
        end else begin
            cdb_o.valid <= issue_valid_i;
        end
    end

    // result and tag
    always_ff @(posedge clk) begin
        cdb_o.rob_idx <= issue_i.rob_idx;
        cdb_o.data    <= result;
    end

endmodule

// File: mul_unit.sv
`timescale 1ns/1ns

module mul_unit (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            issue_valid_i,
    input  ooo_pkg::issue_t issue_i,
    output ooo_pkg::cdb_t   cdb_o
);

    import ooo_pkg::*;

    // control that rides along with the data
    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        logic     hi;
    } mul_ctrl_t;

    mul_ctrl_t ctrl_q [MUL_STAGES];

    // stage 1 operands
    word_t s1_a_q;
    word_t s1_b_q;
    // stage 2 partial products, 16x16 each
    word_t s2_ll_q;
    word_t s2_lh_q;
    word_t s2_hl_q;
    word_t s2_hh_q;
    // stage 3 full product
    prod_t s3_prod_q;
    prod_t prod_sum;

    // valid chain with tag and half select
    always_ff @(posedge clk) begin
        ctrl_q[0].rob_idx <= issue_i.rob_idx;
        ctrl_q[0].hi      <= (issue_i.op == MUL_HIU);
        for (int i = 1; i < MUL_STAGES; i++) begin
            ctrl_q[i].rob_idx <= ctrl_q[i-1].rob_idx;
            ctrl_q[i].hi      <= ctrl_q[i-1].hi;
        end
        if (rst_i) begin
            for (int i = 0; i < MUL_STAGES; i++) begin
                ctrl_q[i].valid <= 1'b0;
            end
            cdb_o.valid <= 1'b0;
        end else begin
            ctrl_q[0].valid <= issue_valid_i;
            for (int i = 1; i < MUL_STAGES; i++) begin
                ctrl_q[i].valid <= ctrl_q[i-1].valid;
            end
            cdb_o.valid <= ctrl_q[MUL_STAGES-1].valid;
        end
    end

    // shifted partial products, all unsigned
    assign prod_sum = {s2_hh_q, 32'd0}
                    + {16'd0, s2_lh_q, 16'd0}
                    + {16'd0, s2_hl_q, 16'd0}
                    + {32'd0, s2_ll_q};

    always_ff @(posedge clk) begin
        s1_a_q    <= issue_i.src_a;
        s1_b_q    <= issue_i.src_b;
        s2_ll_q   <= s1_a_q[15:0]  * s1_b_q[15:0];
        s2_lh_q   <= s1_a_q[15:0]  * s1_b_q[31:16];
        s2_hl_q   <= s1_a_q[31:16] * s1_b_q[15:0];
        s2_hh_q   <= s1_a_q[31:16] * s1_b_q[31:16];
        s3_prod_q <= prod_sum;
    end

    // bus register picks the requested half
    always_ff @(posedge clk) begin
        cdb_o.rob_idx <= ctrl_q[MUL_STAGES-1].rob_idx;
        cdb_o.data    <= ctrl_q[MUL_STAGES-1].hi ? s3_prod_q[63:32] : s3_prod_q[31:0];
    end

endmodule

// File: rob.sv
`timescale 1ns/1ns

module rob (
    input  logic              clk,
    input  logic              rst_i,

    // dispatch from front end
    input  logic              dispatch_valid_i,
    input  ooo_pkg::dispatch_t dispatch_i,
    output logic              dispatch_ready_o,

    // issue to the two units
    output logic              alu_issue_valid_o,
    output logic              mul_issue_valid_o,
    output ooo_pkg::issue_t   issue_o,

    // result channels
    input  ooo_pkg::cdb_t     alu_cdb_i,
    input  ooo_pkg::cdb_t     mul_cdb_i,

    // in-order retirement
    output logic              commit_valid_o,
    output ooo_pkg::commit_t  commit_o,
    input  logic              commit_ready_i
);

    import ooo_pkg::*;

    // slot state, reset to empty
    entry_status_t status_q [ROB_DEPTH];
    // payload per slot
    reg_addr_t     rd_tbl   [ROB_DEPTH];
    word_t         data_tbl [ROB_DEPTH];

    // circular pointers
    rob_idx_t head_q;
    rob_idx_t tail_q;
    // number of occupied slots
    rob_cnt_t count_q;

    logic rob_full;
    logic dispatch_fire;
    logic commit_fire;

    // full when every slot is taken
    assign rob_full = (count_q == rob_cnt_t'(ROB_DEPTH));

    // ready only looks at the stored count
    // so commit never feeds dispatch combinationally
    assign dispatch_ready_o = !rob_full;

    assign dispatch_fire = dispatch_valid_i && dispatch_ready_o;

    // head retires once its result has landed
    assign commit_valid_o = (status_q[head_q] == ST_DONE);
    assign commit_fire    = commit_valid_o && commit_ready_i;

    // steer to the matching unit
    assign alu_issue_valid_o = dispatch_fire && (dispatch_i.unit == UNIT_ALU);
    assign mul_issue_valid_o = dispatch_fire && (dispatch_i.unit == UNIT_MUL);

    // shared payload, tagged with the tail slot
    always_comb begin
        issue_o.rob_idx = tail_q;
        issue_o.op      = dispatch_i.op;
        issue_o.src_a   = dispatch_i.src_a;
        issue_o.src_b   = dispatch_i.src_b;
    end

    // head entry presented on the commit port
    always_comb begin
        commit_o.rob_idx = head_q;
        commit_o.rd_addr = rd_tbl[head_q];
        commit_o.rd_data = data_tbl[head_q];
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (dispatch_fire) begin
                tail_q <= (tail_q == rob_idx_t'(ROB_DEPTH - 1)) ? '0 : tail_q + 1'b1;
            end
            if (commit_fire) begin
                head_q <= (head_q == rob_idx_t'(ROB_DEPTH - 1)) ? '0 : head_q + 1'b1;
            end
            // simultaneous dispatch and commit keep the count
            case ({dispatch_fire, commit_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // slot status
    // the three writers never hit the same slot in one cycle:
    // tail is empty, bus targets are waiting, head is done
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                status_q[i] <= ST_EMPTY;
            end
        end else begin
            // retire head
            if (commit_fire) begin
                status_q[head_q] <= ST_EMPTY;
            end
            // results out of order
            if (alu_cdb_i.valid) begin
                status_q[alu_cdb_i.rob_idx] <= ST_DONE;
            end
            if (mul_cdb_i.valid) begin
                status_q[mul_cdb_i.rob_idx] <= ST_DONE;
            end
            // allocate at tail
            if (dispatch_fire) begin
                status_q[tail_q] <= ST_WAIT;
            end
        end
    end

    // destination register captured at allocation
    always_ff @(posedge clk) begin
        if (dispatch_fire) begin
            rd_tbl[tail_q] <= dispatch_i.rd_addr;
        end
    end

    // both channels may write in the same cycle
    always_ff @(posedge clk) begin
        if (alu_cdb_i.valid) begin
            data_tbl[alu_cdb_i.rob_idx] <= alu_cdb_i.data;
        end
        if (mul_cdb_i.valid) begin
            data_tbl[mul_cdb_i.rob_idx] <= mul_cdb_i.data;
        end
    end

endmodule

// File: exec_core.sv
`timescale 1ns/1ns

module exec_core (
    input  logic               clk,
    input  logic               rst_i,

    // front end side
    input  logic               dispatch_valid_i,
    input  ooo_pkg::dispatch_t dispatch_i,
    output logic               dispatch_ready_o,

    // retirement side
    output logic               commit_valid_o,
    output ooo_pkg::commit_t   commit_o,
    input  logic               commit_ready_i
);

    import ooo_pkg::*;

    // issue path, no ready since units never stall
    logic   alu_issue_valid;
    logic   mul_issue_valid;
    issue_t issue;

    // one bus channel per unit
    cdb_t   alu_cdb;
    cdb_t   mul_cdb;

    rob i_rob (
        .clk               (clk),
        .rst_i             (rst_i),
        .dispatch_valid_i  (dispatch_valid_i),
        .dispatch_i        (dispatch_i),
        .dispatch_ready_o  (dispatch_ready_o),
        .alu_issue_valid_o (alu_issue_valid),
        .mul_issue_valid_o (mul_issue_valid),
        .issue_o           (issue),
        .alu_cdb_i         (alu_cdb),
        .mul_cdb_i         (mul_cdb),
        .commit_valid_o    (commit_valid_o),
        .commit_o          (commit_o),
        .commit_ready_i    (commit_ready_i)
    );

    // single cycle
    alu_unit i_alu_unit (
        .clk           (clk),
        .rst_i         (rst_i),
        .issue_valid_i (alu_issue_valid),
        .issue_i       (issue),
        .cdb_o         (alu_cdb)
    );

    // pipelined, several in flight
    mul_unit i_mul_unit (
        .clk           (clk),
        .rst_i         (rst_i),
        .issue_valid_i (mul_issue_valid),
        .issue_i       (issue),
        .cdb_o         (mul_cdb)
    );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic rst_o
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // reset spans three rising edges, released with the input drive delay
    initial begin
        rst_o = 1'b1;
        repeat (3) @(posedge clk);
        #5;
        rst_o = 1'b0;
    end

endmodule

// File: exec_core_properties.sv
`timescale 1ns/1ns

module exec_core_properties (
    input logic              clk,
    input logic              rst_i,
    input ooo_pkg::rob_cnt_t count_i,
    input logic              dispatch_valid_i,
    input logic              dispatch_ready_i,
    input logic              alu_issue_valid_i,
    input logic              mul_issue_valid_i,
    input logic              commit_valid_i,
    input ooo_pkg::commit_t  commit_i,
    input logic              commit_ready_i
);

    import ooo_pkg::*;

    // failed assertions, read by the testbench summary
    int fail_count = 0;

    // occupancy bounded by the slot count
    count_bound: assert property (@(posedge clk) disable iff (rst_i)
        count_i <= rob_cnt_t'(ROB_DEPTH))
        else begin
            $error("rob occupancy above %0d", ROB_DEPTH);
            fail_count++;
        end

    // stalled commit keeps valid and payload
    commit_hold: assert property (@(posedge clk) disable iff (rst_i)
        commit_valid_i && !commit_ready_i |=> commit_valid_i && $stable(commit_i))
        else begin
            $error("commit payload changed while stalled");
            fail_count++;
        end

    // full buffer takes nothing
    full_no_dispatch: assert property (@(posedge clk) disable iff (rst_i)
        count_i == rob_cnt_t'(ROB_DEPTH) |-> !(dispatch_valid_i && dispatch_ready_i))
        else begin
            $error("dispatch accepted while rob full");
            fail_count++;
        end

    // one unit per dispatch
    issue_onehot: assert property (@(posedge clk) disable iff (rst_i)
        !(alu_issue_valid_i && mul_issue_valid_i))
        else begin
            $error("both issue valids high");
            fail_count++;
        end

endmodule

bind rob exec_core_properties i_rob_properties (
    .clk               (clk),
    .rst_i             (rst_i),
    .count_i           (count_q),
    .dispatch_valid_i  (dispatch_valid_i),
    .dispatch_ready_i  (dispatch_ready_o),
    .alu_issue_valid_i (alu_issue_valid_o),
    .mul_issue_valid_i (mul_issue_valid_o),
    .commit_valid_i    (commit_valid_o),
    .commit_i          (commit_o),
    .commit_ready_i    (commit_ready_i)
);

// File: exec_core_tb.sv
`timescale 1ns/1ns

module exec_core_tb;

    import ooo_pkg::*;

    // table row, expected value worked by hand
    typedef struct packed {
        unit_t     unit;
        alu_op_t   op;
        reg_addr_t rd;
        word_t     a;
        word_t     b;
        word_t     expected;
    } vector_t;

    // what the commit port should show next
    typedef struct packed {
        reg_addr_t rd;
        word_t     data;
    } result_t;

    logic      clk;
    logic      rst_i;
    logic      dispatch_valid;
    dispatch_t dispatch;
    logic      dispatch_ready;
    logic      commit_valid;
    commit_t   commit;
    logic      commit_ready;

    vector_t vectors [24];
    result_t pending [$];
    // separate streams for ops and back-pressure
    word_t   op_state = 32'd94;
    word_t   bp_state = 32'd94;
    logic    bp_random = 1'b0;
    int      error_count = 0;
    int      dispatch_count = 0;
    int      commit_count = 0;

    tb_clock_gen i_clock_gen (.clk(clk), .rst_o(rst_i));

    exec_core i_exec_core (
        .clk              (clk),
        .rst_i            (rst_i),
        .dispatch_valid_i (dispatch_valid),
        .dispatch_i       (dispatch),
        .dispatch_ready_o (dispatch_ready),
        .commit_valid_o   (commit_valid),
        .commit_o         (commit),
        .commit_ready_i   (commit_ready)
    );

    function automatic word_t lcg_step(inout word_t state);
        state = state * 32'd1103515245 + 32'd12345;
        return state;
    endfunction

    // reference results from the op code definitions
    function automatic word_t model_result(unit_t unit, alu_op_t op, word_t a, word_t b);
        logic [63:0] product;
        product = {32'd0, a} * {32'd0, b};
        if (unit == UNIT_MUL) begin
            return (op == MUL_HIU) ? product[63:32] : product[31:0];
        end
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            // differing signs settle it, else plain magnitude
            default: return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
        endcase
    endfunction

    task automatic load_vectors();
        vectors[0]  = '{UNIT_ALU, ALU_ADD, 5'd1,  32'h0000_0005, 32'h0000_0007, 32'h0000_000C};
        vectors[1]  = '{UNIT_ALU, ALU_SUB, 5'd2,  32'h0000_0003, 32'h0000_0005, 32'hFFFF_FFFE};
        vectors[2]  = '{UNIT_ALU, ALU_AND, 5'd3,  32'hF0F0_F0F0, 32'hFF00_FF00, 32'hF000_F000};
        vectors[3]  = '{UNIT_ALU, ALU_OR,  5'd4,  32'hF0F0_F0F0, 32'h0F00_0F00, 32'hFFF0_FFF0};
        vectors[4]  = '{UNIT_ALU, ALU_XOR, 5'd5,  32'hAAAA_5555, 32'hFFFF_0000, 32'h5555_5555};
        vectors[5]  = '{UNIT_ALU, ALU_SLL, 5'd6,  32'h0000_0001, 32'h0000_001F, 32'h8000_0000};
        vectors[6]  = '{UNIT_ALU, ALU_SRL, 5'd7,  32'h8000_0000, 32'h0000_001F, 32'h0000_0001};
        vectors[7]  = '{UNIT_ALU, ALU_SLL, 5'd8,  32'h0000_0003, 32'h0000_0024, 32'h0000_0030};
        vectors[8]  = '{UNIT_ALU, ALU_SRL, 5'd9,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001};
        vectors[9]  = '{UNIT_ALU, ALU_SLT, 5'd10, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0001};
        vectors[10] = '{UNIT_ALU, ALU_SLT, 5'd11, 32'h0000_0001, 32'hFFFF_FFFF, 32'h0000_0000};
        vectors[11] = '{UNIT_ALU, ALU_SLT, 5'd12, 32'h8000_0000, 32'h7FFF_FFFF, 32'h0000_0001};
        vectors[12] = '{UNIT_MUL, MUL_LO,  5'd13, 32'h0000_0006, 32'h0000_0007, 32'h0000_002A};
        vectors[13] = '{UNIT_MUL, MUL_HIU, 5'd14, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE};
        vectors[14] = '{UNIT_MUL, MUL_LO,  5'd15, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001};
        // alu result lands before the multiplies ahead of it
        vectors[15] = '{UNIT_ALU, ALU_ADD, 5'd16, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000};
        vectors[16] = '{UNIT_MUL, MUL_HIU, 5'd17, 32'h0001_0000, 32'h0001_0000, 32'h0000_0001};
        vectors[17] = '{UNIT_ALU, ALU_SUB, 5'd18, 32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF};
        vectors[18] = '{UNIT_MUL, MUL_LO,  5'd19, 32'h1234_5678, 32'h0000_0010, 32'h2345_6780};
        vectors[19] = '{UNIT_MUL, MUL_HIU, 5'd20, 32'h1234_5678, 32'h0000_0010, 32'h0000_0001};
        vectors[20] = '{UNIT_ALU, ALU_XOR, 5'd21, 32'h1234_5678, 32'h1234_5678, 32'h0000_0000};
        vectors[21] = '{UNIT_MUL, MUL_LO,  5'd22, 32'h0000_FFFF, 32'h0000_FFFF, 32'hFFFE_0001};
        vectors[22] = '{UNIT_ALU, ALU_AND, 5'd23, 32'h1234_5678, 32'h0000_FFFF, 32'h0000_5678};
        vectors[23] = '{UNIT_MUL, MUL_HIU, 5'd24, 32'h8000_0000, 32'h8000_0000, 32'h4000_0000};
    endtask

    // called 5 ns after an edge, returns 5 ns after the transfer edge
    task automatic send_op(input dispatch_t op_in, input word_t expected);
        result_t entry;
        entry.rd   = op_in.rd_addr;
        entry.data = expected;
        dispatch       = op_in;
        dispatch_valid = 1'b1;
        // ready comes from stored state only, steady until the edge
        while (!dispatch_ready) begin
            @(posedge clk);
            #5;
        end
        pending.push_back(entry);
        dispatch_count++;
        @(posedge clk);
        #5;
        dispatch_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (pending.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        #5;
    endtask

    task automatic print_summary();
        $display("summary: errors=%0d assertion_failures=%0d dispatched=%0d committed=%0d",
                 error_count, i_exec_core.i_rob.i_rob_properties.fail_count,
                 dispatch_count, commit_count);
    endtask

    // commit port sampled mid cycle, transfer happens at the next edge
    always @(negedge clk) begin : commit_monitor
        result_t exp_res;
        if (!rst_i && commit_valid && commit_ready) begin
            if (pending.size() == 0) begin
                $display("commit at %0t with no operation outstanding", $time);
                error_count++;
            end else begin
                exp_res = pending.pop_front();
                if (commit.rd_addr !== exp_res.rd || commit.rd_data !== exp_res.data) begin
                    $display("ERROR at %0t: commit rd=%0d data=%h, expected rd=%0d data=%h",
                             $time, commit.rd_addr, commit.rd_data, exp_res.rd, exp_res.data);
                    error_count++;
                end
            end
            // slots handed out from zero in order
            if (commit.rob_idx !== rob_idx_t'(commit_count)) begin
                $display("ERROR at %0t: commit slot %0d, expected %0d",
                         $time, commit.rob_idx, rob_idx_t'(commit_count));
                error_count++;
            end
            commit_count++;
        end
    end

    // mode is read at the edge, drive follows the usual delay
    always @(posedge clk) begin
        if (bp_random) begin
            #5;
            void'(lcg_step(bp_state));
            commit_ready = bp_state[29];
        end
    end

    // table, fill, random ops and margin, twenty cycles apiece
    initial begin
        #((224 + 3 * 16 + 50) * 20 * 40);
        $display("timeout: run did not finish in the allotted cycles");
        print_summary();
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        dispatch_t d;
        word_t     r;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        commit_ready   = 1'b0;
        load_vectors();
        @(negedge rst_i);
        if (commit_valid !== 1'b0 || dispatch_ready !== 1'b1) begin
            $display("ERROR at %0t: after reset commit_valid=%b dispatch_ready=%b",
                     $time, commit_valid, dispatch_ready);
            error_count++;
        end
        commit_ready = 1'b1;
        for (int i = 0; i < 24; i++) begin
            d.unit    = vectors[i].unit;
            d.op      = vectors[i].op;
            d.rd_addr = vectors[i].rd;
            d.src_a   = vectors[i].a;
            d.src_b   = vectors[i].b;
            send_op(d, vectors[i].expected);
        end
        wait_drain();
        // commit held, odd slots multiply since add and low product share code 0
        commit_ready = 1'b0;
        for (int i = 0; i < 16; i++) begin
            d.unit    = unit_t'(i % 2);
            d.op      = ALU_ADD;
            d.rd_addr = reg_addr_t'(i);
            d.src_a   = word_t'(i);
            d.src_b   = 32'd3;
            send_op(d, model_result(d.unit, d.op, d.src_a, d.src_b));
        end
        if (pending.size() != 16 || dispatch_ready !== 1'b0) begin
            $display("ERROR at %0t: %0d outstanding with ready=%b, expected 16 and 0",
                     $time, pending.size(), dispatch_ready);
            error_count++;
        end
        // seventeenth request waits on a full buffer
        d.unit    = UNIT_MUL;
        d.op      = MUL_HIU;
        d.rd_addr = 5'd31;
        d.src_a   = 32'hFFFF_FFFF;
        d.src_b   = 32'h0000_0002;
        dispatch       = d;
        dispatch_valid = 1'b1;
        repeat (8) begin
            @(posedge clk);
            #5;
            if (dispatch_ready !== 1'b0) begin
                $display("ERROR at %0t: dispatch_ready high with a full ROB", $time);
                error_count++;
            end
        end
        commit_ready = 1'b1;
        send_op(d, 32'h0000_0001);
        wait_drain();
        bp_random = 1'b1;
        for (int n = 0; n < 200; n++) begin
            r = lcg_step(op_state);
            d.unit    = unit_t'(r[30]);
            d.op      = (r[30]) ? alu_op_t'({2'b00, r[29]}) : alu_op_t'(r[28:26]);
            d.rd_addr = r[24:20];
            d.src_a   = lcg_step(op_state);
            d.src_b   = lcg_step(op_state);
            send_op(d, model_result(d.unit, d.op, d.src_a, d.src_b));
        end
        bp_random = 1'b0;
        @(posedge clk);
        #5;
        commit_ready = 1'b1;
        wait_drain();
        if (commit_count != dispatch_count || pending.size() != 0) begin
            $display("ERROR at %0t: %0d dispatched, %0d committed, %0d still queued",
                     $time, dispatch_count, commit_count, pending.size());
            error_count++;
        end
        print_summary();
        if (error_count == 0 && i_exec_core.i_rob.i_rob_properties.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
ooo_pkg.sv
alu_unit.sv
mul_unit.sv
rob.sv
exec_core.sv
tb_clock_gen.sv
exec_core_properties.sv
exec_core_tb.sv
